/* hw/isaPkg.sv */
package isaPkg;

    parameter int XLEN  = 32;  // operand and immediate width
    parameter int TAG_W = 8;   // physical register tag

    // four-bit ALU opcode as carried in the issue payload
    typedef enum logic [3:0] {
        aluAdd  = 4'h0,
        aluSub  = 4'h1,
        aluAnd  = 4'h2,
        aluOr   = 4'h3,
        aluXor  = 4'h4,
        aluSll  = 4'h5,
        aluSrl  = 4'h6,
        aluSra  = 4'h7,
        aluSlt  = 4'h8,
        aluSltu = 4'h9
    } aluOpE;

    typedef logic [2:0] funct3T;  // passed through to the ALU untouched

endpackage

/* hw/rsPkg.sv */
package rsPkg;

    typedef struct packed {
        logic                      valid;  // data present
        logic [isaPkg::TAG_W-1:0]  tag;    // producer when not valid
        logic [isaPkg::XLEN-1:0]   data;
    } operandT;

    typedef struct packed {
        logic [isaPkg::XLEN-1:0]   pc;
        logic [isaPkg::TAG_W-1:0]  rd;
        isaPkg::aluOpE             aluOp;
        isaPkg::funct3T            funct3;
        logic                      src1Imm;  // ALUSrc1
        logic                      src2Imm;  // ALUSrc2
        logic [isaPkg::XLEN-1:0]   imm;
        operandT                   src1;
        operandT                   src2;
    } dispatchT;

    typedef struct packed {
        logic                      valid;
        logic [isaPkg::TAG_W-1:0]  tag;
        logic [isaPkg::XLEN-1:0]   data;
    } cdbT;

    typedef struct packed {
        logic      busy;
        dispatchT  op;
    } entryT;

    typedef struct packed {
        logic [isaPkg::XLEN-1:0]   pc;
        logic [isaPkg::TAG_W-1:0]  rd;
        isaPkg::aluOpE             aluOp;
        isaPkg::funct3T            funct3;
        logic                      src1Imm;
        logic                      src2Imm;
        logic [isaPkg::XLEN-1:0]   imm;
        logic [isaPkg::XLEN-1:0]   src1Data;
        logic [isaPkg::XLEN-1:0]   src2Data;
    } issueT;

    // take data from one broadcast bus if it names the awaited tag
    function automatic operandT snoop(operandT opnd, cdbT bus);
        operandT res;
        res = opnd;
        if (!opnd.valid && bus.valid && bus.tag == opnd.tag) begin
            res.valid = 1'b1;
            res.data  = bus.data;
        end
        return res;
    endfunction

endpackage

/* hw/rsDispatch.sv */
module rsDispatch #(
    parameter int NUM_CDB = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             dispReq,
    input  rsPkg::dispatchT  dispOp,
    output logic             dispAck,
    input  rsPkg::cdbT       cdb [NUM_CDB],
    input  logic             full,
    output logic             wrEn,
    output rsPkg::dispatchT  wrOp
);
    import rsPkg::*;

    typedef enum logic {
        waitReq,
        waitDrop
    } stateE;

    stateE state;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= waitReq;
        end else begin
            case (state)
                waitReq: begin
                    if (wrEn) begin
                        state <= waitDrop;  // written at this edge
                    end
                end
                waitDrop: begin
                    if (!dispReq) begin
                        state <= waitReq;
                    end
                end
                default: begin
                    state <= waitReq;
                end
            endcase
        end
    end

    assign wrEn    = (state == waitReq) && dispReq && !full;  // stalls while full
    assign dispAck = (state == waitDrop);

    // same-cycle capture from any bus
    always_comb begin
        wrOp = dispOp;
        for (int c = 0; c < NUM_CDB; c++) begin
            wrOp.src1 = snoop(wrOp.src1, cdb[c]);
            wrOp.src2 = snoop(wrOp.src2, cdb[c]);
        end
    end

endmodule

/* hw/rsEntryArray.sv */
module rsEntryArray #(
    parameter int NUM_ENTRIES = 8,
    parameter int NUM_CDB     = 2
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wrEn,
    input  rsPkg::dispatchT         wrOp,
    output logic                    full,
    input  rsPkg::cdbT              cdb [NUM_CDB],
    input  logic [NUM_ENTRIES-1:0]  takeVec,
    output logic [NUM_ENTRIES-1:0]  readyVec,
    output rsPkg::entryT            entries [NUM_ENTRIES]
);
    import rsPkg::*;

    logic [NUM_ENTRIES-1:0] busyQ;
    logic [NUM_ENTRIES-1:0] freeOh;
    dispatchT               opQ [NUM_ENTRIES];
    dispatchT               opNext [NUM_ENTRIES];

    assign full   = &busyQ;
    assign freeOh = ~busyQ & (busyQ + 1'b1);  // lowest clear bit, zero when full

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busyQ <= '0;
        end else begin
            busyQ <= (busyQ & ~takeVec) | ({NUM_ENTRIES{wrEn}} & freeOh);
        end
    end

    // wakeup of waiting operands, new op into the free slot
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            opNext[i] = opQ[i];
            if (busyQ[i]) begin
                for (int c = 0; c < NUM_CDB; c++) begin
                    opNext[i].src1 = snoop(opNext[i].src1, cdb[c]);
                    opNext[i].src2 = snoop(opNext[i].src2, cdb[c]);
                end
            end
            if (wrEn && freeOh[i]) begin
                opNext[i] = wrOp;  // already snooped by dispatch
            end
        end
    end

    always_ff @(posedge clk) begin
        opQ <= opNext;
    end

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            readyVec[i]     = busyQ[i] && opQ[i].src1.valid && opQ[i].src2.valid;
            entries[i].busy = busyQ[i];
            entries[i].op   = opQ[i];
        end
    end

endmodule

/* hw/rsIssueSelect.sv */
module rsIssueSelect #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [NUM_ENTRIES-1:0]  readyVec,
    input  rsPkg::entryT            entries [NUM_ENTRIES],
    output logic [NUM_ENTRIES-1:0]  takeVec,
    output logic                    issueReq,
    input  logic                    issueAck,
    output rsPkg::issueT            issueOp
);
    import rsPkg::*;

    typedef enum logic [1:0] {
        idle,
        waitAck,
        waitRelease
    } stateE;

    stateE                  state;
    logic [NUM_ENTRIES-1:0] pickOh;
    logic                   pickEn;
    dispatchT               pickOp;

    assign pickOh   = readyVec & (~readyVec + 1'b1);  // lowest ready slot
    assign pickEn   = (state == idle) && !issueAck && (readyVec != '0);
    assign takeVec  = {NUM_ENTRIES{pickEn}} & pickOh;
    assign issueReq = (state == waitAck);

    always_comb begin
        pickOp = entries[0].op;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (pickOh[i]) begin
                pickOp = entries[i].op;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (pickEn) begin
                        state <= waitAck;
                    end
                end
                waitAck: begin
                    if (issueAck) begin
                        state <= waitRelease;  // drop req
                    end
                end
                waitRelease: begin
                    if (!issueAck) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // held stable until the next pick
    always_ff @(posedge clk) begin
        if (pickEn) begin
            issueOp.pc       <= pickOp.pc;
            issueOp.rd       <= pickOp.rd;
            issueOp.aluOp    <= pickOp.aluOp;
            issueOp.funct3   <= pickOp.funct3;
            issueOp.src1Imm  <= pickOp.src1Imm;
            issueOp.src2Imm  <= pickOp.src2Imm;
            issueOp.imm      <= pickOp.imm;
            issueOp.src1Data <= pickOp.src1.data;
            issueOp.src2Data <= pickOp.src2.data;
        end
    end

endmodule

/* hw/rsTop.sv */
module rsTop #(
    parameter int NUM_ENTRIES = 8,
    parameter int NUM_CDB     = 2   // execution result and load data
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             dispReq,
    input  rsPkg::dispatchT  dispOp,
    output logic             dispAck,
    input  rsPkg::cdbT       cdb [NUM_CDB],
    output logic             issueReq,
    input  logic             issueAck,
    output rsPkg::issueT     issueOp
);
    import rsPkg::*;

    logic                   wrEn;
    dispatchT               wrOp;
    logic                   full;
    logic [NUM_ENTRIES-1:0] readyVec;
    logic [NUM_ENTRIES-1:0] takeVec;
    entryT                  entries [NUM_ENTRIES];

    rsDispatch #(
        .NUM_CDB (NUM_CDB)
    ) i_dispatch (
        .clk     (clk),
        .reset   (reset),
        .dispReq (dispReq),
        .dispOp  (dispOp),
        .dispAck (dispAck),
        .cdb     (cdb),
        .full    (full),
        .wrEn    (wrEn),
        .wrOp    (wrOp)
    );

    rsEntryArray #(
        .NUM_ENTRIES (NUM_ENTRIES),
        .NUM_CDB     (NUM_CDB)
    ) i_array (
        .clk      (clk),
        .reset    (reset),
        .wrEn     (wrEn),
        .wrOp     (wrOp),
        .full     (full),
        .cdb      (cdb),
        .takeVec  (takeVec),
        .readyVec (readyVec),
        .entries  (entries)
    );

    rsIssueSelect #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_select (
        .clk      (clk),
        .reset    (reset),
        .readyVec (readyVec),
        .entries  (entries),
        .takeVec  (takeVec),
        .issueReq (issueReq),
        .issueAck (issueAck),
        .issueOp  (issueOp)
    );

endmodule

/* test/rs_checker.sv */
module rs_checker (
    input logic          clk,
    input logic          reset,
    input logic          dispReq,
    input logic          dispAck,
    input logic          issueReq,
    input logic          issueAck,
    input rsPkg::issueT  issueOp
);

    // request and payload hold until the unit answers
    assert property (@(posedge clk) disable iff (reset)
        issueReq && !issueAck |=> issueReq && $stable(issueOp))
        else $error("issueReq or issueOp changed before issueAck");

    assert property (@(posedge clk) disable iff (reset)
        $rose(dispAck) |-> $past(dispReq))
        else $error("dispAck rose without a dispatch request");

    assert property (@(posedge clk) disable iff (reset)
        $rose(issueReq) |-> !$past(issueAck))  // previous ack must be gone
        else $error("issueReq rose while issueAck was high");

endmodule

bind rsTop rs_checker i_checker (.*);

/* test/rsTb.sv */
module rsTb;
    import isaPkg::*;
    import rsPkg::*;

    localparam int NUM_ENTRIES  = 8;
    localparam int NUM_CDB      = 2;
    localparam int TIMEOUT      = 200;  // cycles per wait
    localparam int STALL_CYCLES = 6;

    typedef struct packed {
        int       grp;
        int       order;     // expected position in the group's issue sequence
        dispatchT op;
        int       bcOffset;  // -1 none, 0 same cycle as the write
        int       bcBus;
        cdbT      bc;
        issueT    expIssue;
        bit       stall;     // station full, no dispAck until an issue completes
    } rowT;

    logic     clk;
    logic     reset;
    logic     dispReq;
    dispatchT dispOp;
    logic     dispAck;
    cdbT      cdb [NUM_CDB];
    logic     issueReq;
    logic     issueAck;
    issueT    issueOp;

    rowT   rows [$];
    issueT issued [$];
    bit    ackEnable;
    int    seed = 32'hd048_55ac;
    int    errors = 0;
    int    tests = 0;
    int    failedTests = 0;
    string testName [6] = '{"reset", "operands valid", "wakeup", "capture at dispatch",
                            "ordering", "back-pressure"};

    rsTop #(
        .NUM_ENTRIES (NUM_ENTRIES),
        .NUM_CDB     (NUM_CDB)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // a waiting operand takes its tag from d[7:0] and carries poisoned data
    function automatic void addRow(int grp, int order, logic v1, logic [31:0] d1, logic v2,
                                   logic [31:0] d2, int bcOffset, int bcBus, logic [7:0] bcTag,
                                   logic [31:0] bcData, logic [31:0] e1, logic [31:0] e2,
                                   bit stall);
        rowT r;
        int  idx;
        idx = rows.size();
        r.grp        = grp;
        r.order      = order;
        r.op.pc      = 32'h1000 + 4 * idx;
        r.op.rd      = 8'h80 + idx;
        r.op.aluOp   = aluOpE'(idx % 10);
        r.op.funct3  = idx[2:0];
        r.op.src1Imm = idx[0];
        r.op.src2Imm = idx[1];
        r.op.imm     = 32'hf000 + idx;
        r.op.src1    = '{v1, d1[7:0], v1 ? d1 : ~d1};
        r.op.src2    = '{v2, d2[7:0], v2 ? d2 : ~d2};
        r.bcOffset   = bcOffset;
        r.bcBus      = bcBus;
        r.bc         = '{1'b1, bcTag, bcData};
        r.expIssue   = '{r.op.pc, r.op.rd, r.op.aluOp, r.op.funct3, r.op.src1Imm,
                         r.op.src2Imm, r.op.imm, e1, e2};
        r.stall      = stall;
        rows.push_back(r);
    endfunction

    function automatic void clearBus();
        foreach (cdb[c]) begin
            cdb[c] = '0;
        end
    endfunction

    function automatic void reportTest(int g, int errBefore);
        tests++;
        if (errors != errBefore) begin
            failedTests++;
            $display("test %0d %s: FAILED", g, testName[g]);
        end else begin
            $display("test %0d %s: ok", g, testName[g]);
        end
    endfunction

    task automatic dispatchRow(input rowT r);
        int waitCnt;
        dispOp  = r.op;
        dispReq = 1'b1;
        if (r.bcOffset == 0) begin
            cdb[r.bcBus] = r.bc;  // shares the write edge
        end
        if (r.stall) begin
            repeat (STALL_CYCLES) begin
                @(posedge clk);
                #1;
                if (dispAck) begin
                    $display("ERR t=%0t dispAck exp=0 got=1", $time);
                    errors++;
                end
            end
            ackEnable = 1'b1;  // let one issue complete
        end
        waitCnt = 0;
        while (!dispAck && waitCnt < TIMEOUT) begin
            @(posedge clk);
            #1;
            waitCnt++;
        end
        if (!dispAck) begin
            $display("Timeout: dispatch of pc %h was never acknowledged", r.op.pc);
            errors++;
        end
        clearBus();
        dispReq = 1'b0;
        waitCnt = 0;
        while (dispAck && waitCnt < TIMEOUT) begin
            @(posedge clk);
            #1;
            waitCnt++;
        end
        if (dispAck) begin
            $display("Timeout: dispAck stayed high after the request was dropped");
            errors++;
        end
        if (r.bcOffset > 0) begin
            repeat (r.bcOffset) @(posedge clk);
            #1;
            cdb[r.bcBus] = r.bc;
            @(posedge clk);
            #1;
            clearBus();
        end
    endtask

    // execution unit side of the issue handshake
    task automatic runExecUnit(input int count);
        int waitCnt;
        int delay;
        for (int k = 0; k < count; k++) begin
            waitCnt = 0;
            while (!(issueReq && ackEnable) && waitCnt < TIMEOUT) begin
                @(posedge clk);
                #1;
                waitCnt++;
            end
            if (!(issueReq && ackEnable)) begin
                $display("Timeout: issue number %0d never arrived", k);
                errors++;
                return;
            end
            issued.push_back(issueOp);
            delay = 1 + {$random(seed)} % 4;
            repeat (delay) @(posedge clk);
            #1;
            issueAck = 1'b1;
            waitCnt = 0;
            while (issueReq && waitCnt < TIMEOUT) begin
                @(posedge clk);
                #1;
                waitCnt++;
            end
            if (issueReq) begin
                $display("Timeout: issueReq stayed high after issueAck");
                errors++;
            end
            issueAck = 1'b0;
        end
    endtask

    task automatic checkReset();
        int errBefore;
        errBefore = errors;
        if (dispAck !== 1'b0) begin
            $display("ERR t=%0t dispAck exp=0 got=%b", $time, dispAck);
            errors++;
        end
        repeat (8) begin
            @(posedge clk);
            #1;
            if (issueReq !== 1'b0) begin
                $display("ERR t=%0t issueReq exp=0 got=%b", $time, issueReq);
                errors++;
            end
        end
        reportTest(0, errBefore);
    endtask

    task automatic runGroup(input int g);
        int errBefore;
        int count;
        bit hold;
        errBefore = errors;
        count     = 0;
        hold      = 1'b0;
        issued.delete();
        foreach (rows[i]) begin
            if (rows[i].grp == g) begin
                count++;
                hold |= rows[i].stall;
            end
        end
        ackEnable = !hold;
        fork
            begin
                foreach (rows[i]) begin
                    if (rows[i].grp == g) begin
                        dispatchRow(rows[i]);
                    end
                end
            end
            runExecUnit(count);
        join
        foreach (rows[i]) begin
            if (rows[i].grp != g) begin
                continue;
            end
            if (rows[i].order >= issued.size()) begin
                $display("Operation at pc %h did not issue", rows[i].op.pc);
                errors++;
            end else if (issued[rows[i].order] !== rows[i].expIssue) begin
                $display("ERR t=%0t issueOp exp=%h got=%h", $time, rows[i].expIssue,
                         issued[rows[i].order]);
                errors++;
            end
        end
        repeat (2) @(posedge clk);
        #1;
        if (issueReq) begin
            $display("An issue request appeared after the last expected operation");
            errors++;
        end
        reportTest(g, errBefore);
    endtask

    initial begin
        int ord;
        reset     = 1'b1;
        dispReq   = 1'b0;
        dispOp    = '0;
        issueAck  = 1'b0;
        ackEnable = 1'b1;
        clearBus();
        addRow(1, 0, 1, 32'h0000_1234, 1, 32'h0000_5678, -1, 0, 8'h00, 32'h0,
               32'h0000_1234, 32'h0000_5678, 0);
        addRow(1, 1, 1, 32'hffff_fffe, 1, 32'h8000_0001, -1, 0, 8'h00, 32'h0,
               32'hffff_fffe, 32'h8000_0001, 0);
        addRow(2, 1, 1, 32'h0000_0aaa, 0, 32'h0000_0021, 1, 0, 8'h22, 32'h2222_2222,
               32'h0000_0aaa, 32'h2121_2121, 0);  // wrong tag first
        addRow(2, 0, 1, 32'h0000_0bbb, 1, 32'h0000_0ccc, 3, 1, 8'h21, 32'h2121_2121,
               32'h0000_0bbb, 32'h0000_0ccc, 0);
        addRow(3, 0, 0, 32'h0000_0031, 1, 32'h0000_0777, 0, 1, 8'h31, 32'h3131_3131,
               32'h3131_3131, 32'h0000_0777, 0);
        addRow(4, 0, 0, 32'h0000_0040, 1, 32'h0000_0001, -1, 0, 8'h00, 32'h0,
               32'h4040_4040, 32'h0000_0001, 0);
        addRow(4, 1, 1, 32'h0000_0002, 0, 32'h0000_0040, -1, 0, 8'h00, 32'h0,
               32'h0000_0002, 32'h4040_4040, 0);
        addRow(4, 2, 0, 32'h0000_0040, 0, 32'h0000_0040, -1, 0, 8'h00, 32'h0,
               32'h4040_4040, 32'h4040_4040, 0);
        addRow(4, 3, 0, 32'h0000_0040, 1, 32'h0000_0004, 2, 0, 8'h40, 32'h4040_4040,
               32'h4040_4040, 32'h0000_0004, 0);
        // last one refills slot 0 and overtakes slots 1 and up
        for (int k = 0; k < NUM_ENTRIES + 2; k++) begin
            ord = (k < 2) ? k : ((k == NUM_ENTRIES + 1) ? 2 : k + 1);
            addRow(5, ord, 1, 32'h5000_0000 + k, 1, 32'h5500_0000 + k, -1, 0, 8'h00, 32'h0,
                   32'h5000_0000 + k, 32'h5500_0000 + k, k == NUM_ENTRIES + 1);
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        checkReset();
        for (int g = 1; g <= 5; g++) begin
            runGroup(g);
        end
        $display("%0d tests, %0d failed, %0d errors", tests, failedTests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
hw/isaPkg.sv
hw/rsPkg.sv
hw/rsDispatch.sv
hw/rsEntryArray.sv
hw/rsIssueSelect.sv
hw/rsTop.sv
test/rs_checker.sv
test/rsTb.sv

/* Bender.yml */
package:
  name: alu_rs

sources:
  - files:
      - hw/isaPkg.sv
      - hw/rsPkg.sv
      - hw/rsDispatch.sv
      - hw/rsEntryArray.sv
      - hw/rsIssueSelect.sv
      - hw/rsTop.sv
  - target: test
    files:
      - test/rs_checker.sv
      - test/rsTb.sv
